/* core_pkg.sv */
`default_nettype none

package core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int DMEM_WORDS      = 256;
    localparam int DMEM_ADDR_W     = $clog2(DMEM_WORDS);
    localparam int DMEM_READ_DELAY = 2;  // acceptance to rdata_valid.
    localparam int DMEM_WRITE_BUSY = 1;  // not-ready cycles after a write.
    localparam int DMEM_CNT_W      = 4;  // holds either delay.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes and states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_MEM  = 2'd2,
        WB_PC4  = 2'd3
    } wb_sel_e;

    // memory stage FSM.
    typedef enum logic [1:0] {
        WAIT       = 2'd0,
        WAIT_READY = 2'd1,
        WAIT_DATA  = 2'd2
    } stage_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] alu_out;    // address or result.
        logic [31:0] rs2_data;   // store data.
        mem_op_e     mem_op;
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic [4:0]  wb_addr;
        logic        br_flg;
        logic [31:0] br_target;
        logic        jmp_flg;
        logic        is_ecall;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] alu_out;
        logic [31:0] read_data;  // already extended.
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic [4:0]  wb_addr;
        logic        br_flg;
        logic [31:0] br_target;
        logic        jmp_flg;
        logic        is_ecall;
    } mem_wb_t;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wmask;      // byte lane enables.
    } mem_cmd_t;

    typedef struct packed {
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rf_wdata;
        logic        redirect;
        logic [31:0] redirect_pc;
        logic        ecall;
    } wb_out_t;

endpackage

`default_nettype wire

/* ex_mem_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem_latch (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               stall,
    input  core_pkg::ex_mem_t  ex_in,
    output core_pkg::ex_mem_t  ex_mem
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // bubble, payload left as is.
            ex_mem.valid    <= 1'b0;
            ex_mem.mem_op   <= core_pkg::MEM_NONE;
            ex_mem.rf_wen   <= 1'b0;
            ex_mem.wb_sel   <= core_pkg::WB_NONE;
            ex_mem.br_flg   <= 1'b0;
            ex_mem.jmp_flg  <= 1'b0;
            ex_mem.is_ecall <= 1'b0;
        end else if (!stall) begin
            ex_mem <= ex_in;
        end
    end

endmodule

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::ex_mem_t   ex_mem,
    output logic                stall,
    output logic                cmd_start,
    output core_pkg::mem_cmd_t  cmd,
    input  logic                cmd_ready,
    input  logic [31:0]         rdata,
    input  logic                rdata_valid,
    output core_pkg::mem_wb_t   mem_wb
);

    function automatic logic is_store(input core_pkg::mem_op_e op);
        return op inside {core_pkg::MEM_SB, core_pkg::MEM_SH, core_pkg::MEM_SW};
    endfunction

    function automatic logic [3:0] lane_mask(input core_pkg::mem_op_e op);
        case (op)
            core_pkg::MEM_SB: return 4'b0001;
            core_pkg::MEM_SH: return 4'b0011;
            core_pkg::MEM_SW: return 4'b1111;
            default:          return 4'b0000;  // loads write nothing.
        endcase
    endfunction

    function automatic logic [31:0] load_extend(input core_pkg::mem_op_e op,
                                                input logic [31:0] word);
        case (op)
            core_pkg::MEM_LB:  return {{24{word[7]}}, word[7:0]};
            core_pkg::MEM_LBU: return {24'b0, word[7:0]};
            core_pkg::MEM_LH:  return {{16{word[15]}}, word[15:0]};
            core_pkg::MEM_LHU: return {16'b0, word[15:0]};
            default:           return word;
        endcase
    endfunction

    core_pkg::stage_state_e state;
    core_pkg::ex_mem_t      saved;
    core_pkg::ex_mem_t      cur;
    logic                   cur_mem;
    logic                   cur_store;
    logic                   accept;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // current instruction and command
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign cur       = (state == core_pkg::WAIT) ? ex_mem : saved;  // live or held copy.
    assign cur_mem   = cur.valid && (cur.mem_op != core_pkg::MEM_NONE);
    assign cur_store = is_store(cur.mem_op);
    assign accept    = cmd_start && cmd_ready;

    assign cmd_start = cur_mem && (state != core_pkg::WAIT_DATA);

    assign cmd.write = cur_store;
    assign cmd.addr  = cur.alu_out;
    assign cmd.wdata = cur.rs2_data;  // lanes sit low.
    assign cmd.wmask = lane_mask(cur.mem_op);

    always_comb begin
        if (state == core_pkg::WAIT_DATA) begin
            stall = !rdata_valid;
        end else begin
            stall = cur_mem && !(cur_store && accept);  // only a taken store leaves.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outgoing instruction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        mem_wb.valid     = cur.valid && !stall;
        mem_wb.pc        = cur.pc;
        mem_wb.alu_out   = cur.alu_out;
        mem_wb.read_data = (state == core_pkg::WAIT_DATA) ?
                           load_extend(cur.mem_op, rdata) : 32'b0;
        mem_wb.rf_wen    = cur.rf_wen;
        mem_wb.wb_sel    = cur.wb_sel;
        mem_wb.wb_addr   = cur.wb_addr;
        mem_wb.br_flg    = cur.br_flg;
        mem_wb.br_target = cur.br_target;
        mem_wb.jmp_flg   = cur.jmp_flg;
        mem_wb.is_ecall  = cur.is_ecall;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= core_pkg::WAIT;
        end else begin
            case (state)
                core_pkg::WAIT, core_pkg::WAIT_READY: begin
                    if (cur_mem) begin
                        if (!accept) begin
                            state <= core_pkg::WAIT_READY;
                        end else if (cur_store) begin
                            state <= core_pkg::WAIT;
                        end else begin
                            state <= core_pkg::WAIT_DATA;
                        end
                    end
                end
                core_pkg::WAIT_DATA: begin
                    if (rdata_valid) begin
                        state <= core_pkg::WAIT;
                    end
                end
                default: state <= core_pkg::WAIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_pkg::WAIT) begin
            saved <= ex_mem;  // kept for retry and load return.
        end
    end

endmodule

`default_nettype wire

/* data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_start,
    input  core_pkg::mem_cmd_t  cmd,
    output logic                cmd_ready,
    output logic [31:0]         rdata,
    output logic                rdata_valid
);

    logic [31:0]                          mem [core_pkg::DMEM_WORDS];
    logic [core_pkg::DMEM_ADDR_W-1:0]     word_idx;
    logic [31:0]                          rd_word;
    logic [core_pkg::DMEM_CNT_W-1:0]      rd_cnt;
    logic [core_pkg::DMEM_CNT_W-1:0]      busy_cnt;
    logic                                 accept;

    assign word_idx    = cmd.addr[core_pkg::DMEM_ADDR_W+1:2];  // low two bits dropped.
    assign accept      = cmd_start && cmd_ready;
    assign cmd_ready   = (busy_cnt == '0);
    assign rdata       = rd_word;
    assign rdata_valid = (rd_cnt == core_pkg::DMEM_CNT_W'(1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (accept && cmd.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (cmd.wmask[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= cmd.wdata[lane*8 +: 8];
                end
            end
        end
        if (accept && !cmd.write) begin
            rd_word <= mem[word_idx];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // timing counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cnt   <= '0;
            busy_cnt <= '0;
        end else begin
            if (accept && !cmd.write) begin
                rd_cnt <= core_pkg::DMEM_CNT_W'(core_pkg::DMEM_READ_DELAY);
            end else if (rd_cnt != '0) begin
                rd_cnt <= rd_cnt - 1'b1;
            end
            if (accept && cmd.write) begin
                busy_cnt <= core_pkg::DMEM_CNT_W'(core_pkg::DMEM_WRITE_BUSY);
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;  // write still settling.
            end
        end
    end

endmodule

`default_nettype wire

/* writeback_select.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_select (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::mem_wb_t  mem_wb,
    output core_pkg::wb_out_t  wb_out
);

    logic [31:0] wdata_next;

    always_comb begin
        case (mem_wb.wb_sel)
            core_pkg::WB_ALU: wdata_next = mem_wb.alu_out;
            core_pkg::WB_MEM: wdata_next = mem_wb.read_data;
            core_pkg::WB_PC4: wdata_next = mem_wb.pc + 32'd4;  // link address.
            default:          wdata_next = 32'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_out.rf_we    <= 1'b0;
            wb_out.redirect <= 1'b0;
            wb_out.ecall    <= 1'b0;
        end else begin
            wb_out.rf_we    <= mem_wb.valid && mem_wb.rf_wen && (mem_wb.wb_addr != 5'd0);
            wb_out.redirect <= mem_wb.valid && (mem_wb.br_flg || mem_wb.jmp_flg);
            wb_out.ecall    <= mem_wb.valid && mem_wb.is_ecall;
        end
    end

    always_ff @(posedge clk) begin
        wb_out.rf_waddr    <= mem_wb.wb_addr;
        wb_out.rf_wdata    <= wdata_next;
        wb_out.redirect_pc <= mem_wb.br_target;
    end

endmodule

`default_nettype wire

/* mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  core_pkg::ex_mem_t  ex_in,
    output logic               stall,
    output core_pkg::wb_out_t  wb_out
);

    core_pkg::ex_mem_t   ex_mem;
    core_pkg::mem_wb_t   mem_wb;
    core_pkg::mem_cmd_t  cmd;
    logic                cmd_start;
    logic                cmd_ready;
    logic [31:0]         rdata;
    logic                rdata_valid;

    ex_mem_latch ex_mem_latch_inst (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .stall  (stall),
        .ex_in  (ex_in),
        .ex_mem (ex_mem)
    );

    memory_stage memory_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .ex_mem      (ex_mem),
        .stall       (stall),
        .cmd_start   (cmd_start),
        .cmd         (cmd),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .mem_wb      (mem_wb)
    );

    data_memory data_memory_inst (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (cmd_start),
        .cmd         (cmd),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    writeback_select writeback_select_inst (
        .clk    (clk),
        .rst    (rst),
        .mem_wb (mem_wb),
        .wb_out (wb_out)
    );

endmodule

`default_nettype wire

/* mem_subsystem_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_assert (
    input logic                   clk,
    input logic                   rst,
    input core_pkg::stage_state_e state,
    input logic                   cmd_start,
    input logic                   cmd_ready,
    input core_pkg::mem_cmd_t     cmd,
    input logic                   rdata_valid
);

    int unsigned fail_count = 0;  // failed assertions so far.

    reset_quiet: assert property (@(posedge clk) rst |=> !cmd_start)
        else begin
            fail_count++;
            $error("cmd_start high after a reset cycle");
        end

    // a refused command is offered again unchanged.
    cmd_hold: assert property (@(posedge clk) disable iff (rst)
        (cmd_start && !cmd_ready) |=> (cmd_start && $stable(cmd)))
        else begin
            fail_count++;
            $error("command dropped or changed before acceptance");
        end

    no_data_in_wait: assert property (@(posedge clk) disable iff (rst)
        rdata_valid |-> (state != core_pkg::WAIT))
        else begin
            fail_count++;
            $error("rdata_valid while the stage is in WAIT");
        end

endmodule

bind memory_stage mem_subsystem_assert mem_subsystem_assert_inst (
    .clk         (clk),
    .rst         (rst),
    .state       (state),
    .cmd_start   (cmd_start),
    .cmd_ready   (cmd_ready),
    .cmd         (cmd),
    .rdata_valid (rdata_valid)
);

`default_nettype wire

/* tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_ROWS   = 22;

    typedef struct packed {
        core_pkg::ex_mem_t ex;
        logic              flush;
        logic              no_gap;  // follows the previous row directly.
    } row_t;

    logic              clk;
    logic              rst;
    logic              flush;
    core_pkg::ex_mem_t ex_in;
    logic              stall;
    core_pkg::wb_out_t wb_out;

    row_t              rows [NUM_ROWS];
    logic [31:0]       model_mem [core_pkg::DMEM_WORDS];
    core_pkg::wb_out_t exp_q [$];
    longint            due_q [$];  // 0 when the latency is not fixed.
    logic [15:0]       lfsr_state;
    int                retry_cycles = 0;

    mem_subsystem mem_subsystem_inst (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .ex_in  (ex_in),
        .stall  (stall),
        .wb_out (wb_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_with_failure(input string why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_wb(input core_pkg::wb_out_t got, input core_pkg::wb_out_t want);
        if (got !== want) begin
            $display("[ERROR] %0t wb_out got %h expected %h", $time, got, want);
            stop_with_failure("wb_out mismatch");
        end
    endtask

    task automatic check_stall_idle(input logic got_stall, input core_pkg::wb_out_t got_out);
        if (got_stall !== 1'b0) begin
            $display("[ERROR] %0t stall got %b expected 0", $time, got_stall);
            stop_with_failure("stall high while the design is idle");
        end else if ({got_out.rf_we, got_out.redirect, got_out.ecall} !== 3'b000) begin
            $display("[ERROR] %0t wb_out flags got %b expected 000", $time,
                     {got_out.rf_we, got_out.redirect, got_out.ecall});
            stop_with_failure("wb_out flags set while the design is idle");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11.
    endfunction

    task automatic pick_gap(output int gap);
        gap = 0;
        repeat (2) begin
            gap = (gap << 1) | int'(lfsr_state[15]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic wait_taken();
        @(negedge clk);
        while (stall) @(negedge clk);
        @(posedge clk);  // latch takes ex_in here.
    endtask

    function automatic row_t make_row(input core_pkg::mem_op_e op, input core_pkg::wb_sel_e sel,
                                      input logic [4:0] rd, input logic [31:0] pc,
                                      input logic [31:0] alu, input logic [31:0] rs2,
                                      input logic [2:0] ctl, input logic fl, input logic tight);
        row_t r;
        r.ex.valid     = 1'b1;
        r.ex.pc        = pc;
        r.ex.alu_out   = alu;
        r.ex.rs2_data  = rs2;
        r.ex.mem_op    = op;
        r.ex.rf_wen    = (sel != core_pkg::WB_NONE);
        r.ex.wb_sel    = sel;
        r.ex.wb_addr   = rd;
        r.ex.br_flg    = ctl[2];
        r.ex.br_target = alu;  // target comes from the ALU.
        r.ex.jmp_flg   = ctl[1];
        r.ex.is_ecall  = ctl[0];
        r.flush        = fl;
        r.no_gap       = tight;
        return r;
    endfunction

    task automatic model_row(input row_t r, input longint take_t);
        core_pkg::ex_mem_t e;
        core_pkg::wb_out_t w;
        logic [31:0]       word;
        logic [31:0]       ld;
        int                idx;
        int                nbytes;
        e = r.ex;
        if (r.flush || !e.valid) return;
        idx  = int'((e.alu_out >> 2) % core_pkg::DMEM_WORDS);
        word = model_mem[idx];
        case (e.mem_op)
            core_pkg::MEM_SB: nbytes = 1;
            core_pkg::MEM_SH: nbytes = 2;
            core_pkg::MEM_SW: nbytes = 4;
            default:          nbytes = 0;
        endcase
        for (int b = 0; b < nbytes; b++) begin
            model_mem[idx][b*8 +: 8] = e.rs2_data[b*8 +: 8];
        end
        case (e.mem_op)
            core_pkg::MEM_LB:  ld = $signed(word[7:0]);
            core_pkg::MEM_LBU: ld = word[7:0];
            core_pkg::MEM_LH:  ld = $signed(word[15:0]);
            core_pkg::MEM_LHU: ld = word[15:0];
            core_pkg::MEM_LW:  ld = word;
            default:           ld = '0;
        endcase
        case (e.wb_sel)
            core_pkg::WB_ALU: w.rf_wdata = e.alu_out;
            core_pkg::WB_MEM: w.rf_wdata = ld;
            core_pkg::WB_PC4: w.rf_wdata = e.pc + 32'd4;
            default:          w.rf_wdata = '0;
        endcase
        w.rf_we       = e.rf_wen && (e.wb_addr != 5'd0);
        w.rf_waddr    = e.wb_addr;
        w.redirect    = e.br_flg || e.jmp_flg;
        w.redirect_pc = e.br_target;
        w.ecall       = e.is_ecall;
        if (w.rf_we || w.redirect || w.ecall) begin
            exp_q.push_back(w);
            // non-memory rows leave one edge after the latch takes them.
            due_q.push_back((e.mem_op == core_pkg::MEM_NONE) ?
                            take_t + CLK_PERIOD + CLK_PERIOD / 2 : 0);
        end
    endtask

    // columns: op, wb_sel, rd / pc, alu_out, rs2_data, {br,jmp,ecall}, flush, no gap
    task automatic fill_table();
        rows[0]  = make_row(core_pkg::MEM_NONE, core_pkg::WB_ALU, 5'd5,
                            32'h100, 32'h12345678, 32'h0, 3'b000, 1'b0, 1'b0);
        rows[1]  = make_row(core_pkg::MEM_NONE, core_pkg::WB_ALU, 5'd0,
                            32'h104, 32'hdeadbeef, 32'h0, 3'b000, 1'b0, 1'b0);
        rows[2]  = make_row(core_pkg::MEM_NONE, core_pkg::WB_PC4, 5'd1,
                            32'h108, 32'h200, 32'h0, 3'b010, 1'b0, 1'b0);
        rows[3]  = make_row(core_pkg::MEM_NONE, core_pkg::WB_NONE, 5'd0,
                            32'h200, 32'h180, 32'h0, 3'b100, 1'b0, 1'b0);
        rows[4]  = make_row(core_pkg::MEM_NONE, core_pkg::WB_ALU, 5'd6,
                            32'h180, 32'h55, 32'h0, 3'b000, 1'b1, 1'b0);
        rows[5]  = make_row(core_pkg::MEM_SW, core_pkg::WB_NONE, 5'd0,
                            32'h184, 32'h40, 32'h11223344, 3'b000, 1'b0, 1'b0);
        rows[6]  = make_row(core_pkg::MEM_SB, core_pkg::WB_NONE, 5'd0,
                            32'h188, 32'h41, 32'haaaaaaa5, 3'b000, 1'b0, 1'b1);
        rows[7]  = make_row(core_pkg::MEM_LW, core_pkg::WB_MEM, 5'd7,
                            32'h18c, 32'h40, 32'h0, 3'b000, 1'b0, 1'b1);
        rows[8]  = make_row(core_pkg::MEM_SH, core_pkg::WB_NONE, 5'd0,
                            32'h190, 32'h42, 32'h5555c0de, 3'b000, 1'b0, 1'b0);
        rows[9]  = make_row(core_pkg::MEM_LW, core_pkg::WB_MEM, 5'd14,
                            32'h194, 32'h43, 32'h0, 3'b000, 1'b0, 1'b1);
        rows[10] = make_row(core_pkg::MEM_SW, core_pkg::WB_NONE, 5'd0,
                            32'h198, 32'h80, 32'h7f7f7f7f, 3'b000, 1'b0, 1'b0);
        rows[11] = make_row(core_pkg::MEM_SH, core_pkg::WB_NONE, 5'd0,
                            32'h19c, 32'h80, 32'hffff8081, 3'b000, 1'b0, 1'b1);
        rows[12] = make_row(core_pkg::MEM_LB, core_pkg::WB_MEM, 5'd8,
                            32'h1a0, 32'h80, 32'h0, 3'b000, 1'b0, 1'b1);
        rows[13] = make_row(core_pkg::MEM_LBU, core_pkg::WB_MEM, 5'd9,
                            32'h1a4, 32'h81, 32'h0, 3'b000, 1'b0, 1'b0);
        rows[14] = make_row(core_pkg::MEM_LH, core_pkg::WB_MEM, 5'd10,
                            32'h1a8, 32'h82, 32'h0, 3'b000, 1'b0, 1'b0);
        rows[15] = make_row(core_pkg::MEM_LHU, core_pkg::WB_MEM, 5'd11,
                            32'h1ac, 32'h83, 32'h0, 3'b000, 1'b0, 1'b0);
        rows[16] = make_row(core_pkg::MEM_LW, core_pkg::WB_MEM, 5'd0,
                            32'h1b0, 32'h80, 32'h0, 3'b000, 1'b0, 1'b0);
        rows[17] = make_row(core_pkg::MEM_NONE, core_pkg::WB_NONE, 5'd0,
                            32'h1b4, 32'h0, 32'h0, 3'b001, 1'b0, 1'b0);
        rows[18] = make_row(core_pkg::MEM_NONE, core_pkg::WB_ALU, 5'd31,
                            32'h1b8, 32'hcafef00d, 32'h0, 3'b000, 1'b0, 1'b0);
        rows[19] = make_row(core_pkg::MEM_NONE, core_pkg::WB_ALU, 5'd13,
                            32'h1bc, 32'h1, 32'h0, 3'b000, 1'b1, 1'b0);
        rows[20] = make_row(core_pkg::MEM_LB, core_pkg::WB_MEM, 5'd12,
                            32'h1c0, 32'h40, 32'h0, 3'b000, 1'b0, 1'b0);
        rows[21] = make_row(core_pkg::MEM_NONE, core_pkg::WB_PC4, 5'd2,
                            32'h300, 32'h400, 32'h0, 3'b010, 1'b0, 1'b0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int gap;
        rst        = 1'b1;
        flush      = 1'b0;
        ex_in      = '0;
        lfsr_state = 16'd49;
        foreach (model_mem[i]) model_mem[i] = '0;
        fill_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_stall_idle(stall, wb_out);
        @(posedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            gap = 0;
            if (!rows[i].no_gap) pick_gap(gap);
            repeat (gap) begin
                ex_in <= '0;  // bubble.
                flush <= 1'b0;
                wait_taken();
            end
            ex_in <= rows[i].ex;
            flush <= rows[i].flush;
            wait_taken();
            model_row(rows[i], longint'($time));
        end
        ex_in <= '0;
        flush <= 1'b0;
        @(negedge clk);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);  // room for stray results.
        check_stall_idle(stall, wb_out);
        if (retry_cycles == 0) begin
            stop_with_failure("no command ever met a busy memory");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    // result monitor and command retry count.
    always @(negedge clk) begin
        core_pkg::wb_out_t want;
        longint            due;
        if (mem_subsystem_inst.memory_stage_inst.mem_subsystem_assert_inst.fail_count != 0) begin
            stop_with_failure("an assertion on the memory command interface failed");
        end else if (!rst) begin
            if (mem_subsystem_inst.cmd_start && !mem_subsystem_inst.cmd_ready) begin
                retry_cycles++;
            end
            if (wb_out.rf_we || wb_out.redirect || wb_out.ecall) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("a result arrived while none was expected");
                end else begin
                    want = exp_q.pop_front();
                    due  = due_q.pop_front();
                    check_wb(wb_out, want);
                    if (due != 0 && due != longint'($time)) begin
                        stop_with_failure($sformatf("result due at %0d ns arrived at %0t",
                                                    due, $time));
                    end
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * 40 * NUM_ROWS);
        stop_with_failure("watchdog expired before all rows completed");
    end

endmodule

`default_nettype wire

/* files.f */
core_pkg.sv
ex_mem_latch.sv
memory_stage.sv
data_memory.sv
writeback_select.sv
mem_subsystem.sv
mem_subsystem_assert.sv
tb_mem_subsystem.sv

/* Makefile */
TOP := tb_mem_subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir
